//--- Bender.yml
package:
  name: cft_mem_subsystem

sources:
  # Shared package first
  - files:
      - design/cft_bus_pkg.sv

  # RTL
  - files:
      - design/bus_port_queue.sv
      - design/bus_arbiter.sv
      - design/card_mem.sv
      - design/mem_subsystem.sv

  # Testbench
  - target: test
    files:
      - test/tb_mem_subsystem.sv

//--- design/bus_arbiter.sv
/* Round-robin arbiter between the port queues. Forwards one head per cycle
   to the memory card and steers each read reply back to its own port */

`timescale 1ns/10ps

module bus_arbiter (
   input  logic                                         clk1,
   input  logic                                         rst_n,
   input  logic [cft_bus_pkg::num_ports-1:0]            head_valid,
   input  cft_bus_pkg::bus_req_s [cft_bus_pkg::num_ports-1:0] head,
   output logic [cft_bus_pkg::num_ports-1:0]            grant,
   output logic                                         card_valid,
   output cft_bus_pkg::card_req_s                       card_req,
   input  logic                                         rsp_valid,
   input  cft_bus_pkg::bus_rsp_s                        rsp,
   output logic [cft_bus_pkg::num_ports-1:0]            rd_valid,
   output logic [cft_bus_pkg::num_ports-1:0][cft_bus_pkg::data_w-1:0] rd_data
);
   import cft_bus_pkg::*;

   logic [port_w-1:0] rr_ptr;                             // Port with first claim
   logic [port_w-1:0] winner;
   logic              any_valid;

   //////////////////////////////////////////////////
   // Selection
   //////////////////////////////////////////////////

   // Scan from farthest to nearest so the port closest to rr_ptr wins
   always_comb begin
      int unsigned idx;
      any_valid = 1'b0;
      winner    = rr_ptr;
      for (int i = num_ports - 1; i >= 0; i--) begin
         idx = (int'(rr_ptr) + i) % num_ports;
         if (head_valid[idx]) begin
            winner    = port_w'(idx);
            any_valid = 1'b1;
         end
      end
   end

   always_comb begin
      grant = '0;
      if (any_valid)
         grant[winner] = 1'b1;                            // Also pops the queue head
   end

   assign card_valid    = any_valid;
   assign card_req.req  = head[winner];
   assign card_req.port = winner;                         // Tag for the reply path

   // Pointer moves one past the winner
   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n)
         rr_ptr <= '0;                                    // Port 0 first after reset
      else if (any_valid)
         rr_ptr <= (winner == port_w'(num_ports - 1)) ? '0 : winner + 1'b1;
   end

   //////////////////////////////////////////////////
   // Reply demux
   //////////////////////////////////////////////////

   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n)
         rd_valid <= '0;
      else
         for (int i = 0; i < num_ports; i++)
            rd_valid[i] <= rsp_valid && (rsp.port == port_w'(i));
   end

   always_ff @(posedge clk1) begin
      if (rsp_valid)
         rd_data[rsp.port] <= rsp.rdata;                  // Only the addressed port moves
   end

   a_grant_onehot: assert property (
      @(posedge clk1) disable iff (!rst_n) $onehot0(grant))
      else $error("more than one grant in a cycle");

endmodule

//--- design/bus_port_queue.sv
/* Request queue for one bus master. Entries are pushed under credit flow
   control and popped by the arbiter grant, which also returns the credit */

`timescale 1ns/10ps

module bus_port_queue (
   input  logic                  clk1,
   input  logic                  rst_n,
   input  logic                  req_valid,
   input  cft_bus_pkg::bus_req_s req,
   output logic                  head_valid,
   output cft_bus_pkg::bus_req_s head,
   input  logic                  grant,
   output logic                  credit_ret
);
   import cft_bus_pkg::*;

   bus_req_s            entry [port_credits];            // Queue storage
   logic [q_ptr_w-1:0]  wr_ptr;
   logic [q_ptr_w-1:0]  rd_ptr;
   logic [q_cnt_w-1:0]  count;                            // Occupancy
   logic                full;
   logic                push;
   logic                pop;

   assign full       = (count == q_cnt_w'(port_credits));
   assign head_valid = (count != '0);
   assign head       = entry[rd_ptr];                     // Head is visible right after push
   assign push       = req_valid && !full;                // Overrun never lands in storage
   assign pop        = grant && head_valid;
   assign credit_ret = pop;                               // One credit per freed entry

   // Pointers and occupancy
   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == q_ptr_w'(port_credits - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == q_ptr_w'(port_credits - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;               // Push only
            2'b01:   count <= count - 1'b1;               // Pop only
            default: count <= count;                      // Both or neither
         endcase
      end
   end

   // Payload store
   always_ff @(posedge clk1) begin
      if (push)
         entry[wr_ptr] <= req;
   end

   //////////////////////////////////////////////////
   // Protocol checks
   //////////////////////////////////////////////////

   // Master must hold a credit, so a full queue never sees a push
   a_credit_overrun: assert property (
      @(posedge clk1) disable iff (!rst_n) req_valid |-> !full)
      else $error("queue push while full (credit overrun)");

   // Arbiter only grants a queue that shows a head
   a_grant_empty: assert property (
      @(posedge clk1) disable iff (!rst_n) grant |-> head_valid)
      else $error("grant to empty queue");

endmodule

//--- design/card_mem.sv
/* Memory card that decodes the bus address into RAM, ROM or unmapped space.
   Writes land in RAM only; reads reply one cycle after the request */

`timescale 1ns/10ps

module card_mem (
   input  logic                   clk1,
   input  logic                   rst_n,
   input  logic                   card_valid,
   input  cft_bus_pkg::card_req_s card_req,
   output logic                   rsp_valid,
   output cft_bus_pkg::bus_rsp_s  rsp
);
   import cft_bus_pkg::*;

   bus_addr_u         addr;                               // Decoder view of the address
   logic              ram_sel;                            // Low decoder bank 0
   logic              rom_sel;                            // ROM decoder bank 0
   logic [mem_aw-1:0] word_idx;                           // Array index
   logic              ram_we;
   logic              rd_en;

   logic [data_w-1:0] ram [2**mem_aw];                    // Two 8-bit chips as one word
   logic [data_w-1:0] rom [2**mem_aw];

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   assign addr = card_req.req.addr;

   // Low decoder enabled with bits 23 and 22 both low
   assign ram_sel = !addr.fields.nbank_hi
                 && !addr.fields.nbank_mid
                 && (addr.fields.chip == 3'd0);

   // ROM decoder enabled with bit 23 high and bit 22 low
   assign rom_sel = addr.fields.nbank_hi
                 && !addr.fields.nbank_mid
                 && (addr.fields.chip == 3'd0);

   // Upper offset bits ignored by the short arrays
   assign word_idx = addr.fields.offset[mem_aw-1:0];

   assign ram_we = card_valid && card_req.req.write && ram_sel;  // ROM and unmapped drop writes
   assign rd_en  = card_valid && !card_req.req.write;

   //////////////////////////////////////////////////
   // Arrays
   //////////////////////////////////////////////////

   // ROM contents come from the hex image once at start
   initial begin
      $readmemh(rom_file, rom);
   end

   always_ff @(posedge clk1) begin
      if (ram_we)
         ram[word_idx] <= card_req.req.wdata;             // Takes effect at the grant edge
   end

   //////////////////////////////////////////////////
   // Read reply
   //////////////////////////////////////////////////

   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= rd_en;                              // Writes get no reply
   end

   // Data and port tag held with the reply
   always_ff @(posedge clk1) begin
      if (rd_en) begin
         rsp.port <= card_req.port;
         if (ram_sel)
            rsp.rdata <= ram[word_idx];
         else if (rom_sel)
            rsp.rdata <= rom[word_idx];
         else
            rsp.rdata <= unmapped_data;                   // Pulled-up bus
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // Decoders are exclusive, so ROM space never reaches the RAM array
   a_rom_write_protect: assert property (
      @(posedge clk1) disable iff (!rst_n) ram_we |-> !rom_sel)
      else $error("RAM written while ROM selected");

endmodule

//--- design/cft_bus_pkg.sv
/* Bus widths, address views and the request and reply records shared by the
   port queues, the arbiter and the memory card. Import it where these are used */

package cft_bus_pkg;

   //////////////////////////////////////////////////
   // Bus geometry
   //////////////////////////////////////////////////

   localparam int unsigned addr_w       = 24;             // Backplane address bus
   localparam int unsigned data_w       = 16;             // One bus word
   localparam int unsigned mem_aw       = 10;             // 1024 words per array in sim
   localparam int unsigned port_credits = 2;              // Queue depth and initial credits
   localparam int unsigned num_ports    = 2;              // Processor and DMA loader

   localparam int unsigned port_w  = (num_ports > 1) ? $clog2(num_ports) : 1;
   localparam int unsigned q_ptr_w = (port_credits > 1) ? $clog2(port_credits) : 1;
   localparam int unsigned q_cnt_w = $clog2(port_credits + 1);  // Holds 0..port_credits

   localparam string rom_file = "test/rom_image.hex";     // ROM hex image

   // Floating bus reads back as pulled-up ones
   localparam logic [data_w-1:0] unmapped_data = '1;

   //////////////////////////////////////////////////
   // Address word
   //////////////////////////////////////////////////

   // Field split matching the board decoders
   typedef struct packed {
      logic        nbank_hi;                              // Bit 23, ROM decoder enable
      logic        nbank_mid;                             // Bit 22, low-bank decoder enable
      logic [2:0]  chip;                                  // Bits 21:19, decoder select
      logic [18:0] offset;                                // Word offset within a chip
   } bus_addr_fields_s;

   typedef union packed {
      logic [addr_w-1:0] raw;                             // Flat bus address
      bus_addr_fields_s  fields;                          // Decoder view
   } bus_addr_u;

   //////////////////////////////////////////////////
   // Transfers
   //////////////////////////////////////////////////

   typedef struct packed {
      logic              write;                           // 1 = write, 0 = read
      bus_addr_u         addr;
      logic [data_w-1:0] wdata;                           // Ignored on reads
   } bus_req_s;

   typedef struct packed {
      logic [port_w-1:0] port;                            // Port the read came from
      logic [data_w-1:0] rdata;
   } bus_rsp_s;

   // Request after arbitration, tagged with its source
   typedef struct packed {
      bus_req_s          req;
      logic [port_w-1:0] port;
   } card_req_s;

endpackage

//--- design/mem_subsystem.sv
/* Top of the memory subsystem. Two credit-controlled request queues feed
   a round-robin arbiter, which shares one memory card between both masters */

`timescale 1ns/10ps

module mem_subsystem (
   input  logic                                         clk1,
   input  logic                                         rst_n,
   input  logic [cft_bus_pkg::num_ports-1:0]            req_valid,
   input  cft_bus_pkg::bus_req_s [cft_bus_pkg::num_ports-1:0] req,
   output logic [cft_bus_pkg::num_ports-1:0]            credit_ret,
   output logic [cft_bus_pkg::num_ports-1:0]            rd_valid,
   output logic [cft_bus_pkg::num_ports-1:0][cft_bus_pkg::data_w-1:0] rd_data
);
   import cft_bus_pkg::*;

   logic [num_ports-1:0]     head_valid;                  // Queue heads to arbiter
   bus_req_s [num_ports-1:0] head;
   logic [num_ports-1:0]     grant;                       // Pops and credit returns
   logic                     card_valid;
   card_req_s                card_req;
   logic                     rsp_valid;                   // Card reply, before routing
   bus_rsp_s                 rsp;

   //////////////////////////////////////////////////
   // Port queues
   //////////////////////////////////////////////////

   // Processor port
   bus_port_queue queue0 (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .req_valid  (req_valid[0]),
      .req        (req[0]),
      .head_valid (head_valid[0]),
      .head       (head[0]),
      .grant      (grant[0]),
      .credit_ret (credit_ret[0])
   );

   // DMA and front-panel loader port
   bus_port_queue queue1 (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .req_valid  (req_valid[1]),
      .req        (req[1]),
      .head_valid (head_valid[1]),
      .head       (head[1]),
      .grant      (grant[1]),
      .credit_ret (credit_ret[1])
   );

   //////////////////////////////////////////////////
   // Arbiter and card
   //////////////////////////////////////////////////

   bus_arbiter u_arbiter (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .head_valid (head_valid),
      .head       (head),
      .grant      (grant),
      .card_valid (card_valid),
      .card_req   (card_req),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data)
   );

   card_mem u_card (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .card_valid (card_valid),
      .card_req   (card_req),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

endmodule

//--- sources.f
design/cft_bus_pkg.sv
design/bus_port_queue.sv
design/bus_arbiter.sv
design/card_mem.sv
design/mem_subsystem.sv
test/tb_mem_subsystem.sv

//--- test/rom_image.hex
// ROM image, one 16-bit hex word per line from offset 0
// Each word is its offset XOR A5C3, words past the list stay unloaded
A5C3
A5C2
A5C1
A5C0
A5C7
A5C6
A5C5
A5C4
A5CB
A5CA
A5C9
A5C8
A5CF
A5CE
A5CD
A5CC
A5D3
A5D2
A5D1
A5D0

//--- test/tb_mem_subsystem.sv
/* Testbench for the memory subsystem. Both masters issue requests under credit
   flow control, a reference memory model predicts every read, and concurrent
   assertions check data, order, latency and credits */

`timescale 1ns/10ps

module tb_mem_subsystem;
   import cft_bus_pkg::*;

   localparam int          max_lat   = 2 + 2 * port_credits;  // Both ports busy
   localparam int          idle_lat  = 2;                     // Lone request on idle bus
   localparam int          idle_wait = 2 * port_credits + 2;  // Quiet cycles before credits home
   localparam int          rom_words = 20;                    // Words present in the ROM image
   localparam logic [15:0] rom_key   = 16'hA5C3;              // ROM word = offset ^ key

   logic                             clk1;
   logic                             rst_n;
   logic [num_ports-1:0]             req_valid;
   bus_req_s [num_ports-1:0]         req;
   logic [num_ports-1:0]             credit_ret;
   logic [num_ports-1:0]             rd_valid;
   logic [num_ports-1:0][data_w-1:0] rd_data;

   //////////////////////////////////////////////////
   // Reference model and scoreboard
   //////////////////////////////////////////////////

   logic [data_w-1:0] ram_shadow [2**mem_aw];             // Expected RAM contents
   logic [data_w-1:0] exp_data   [num_ports][256];        // Expected read data, in order
   int                acc_cyc    [num_ports][256];        // Cycle the read was accepted
   bit                exp_idle   [num_ports][256];        // Read sent on an idle bus
   logic [7:0]        wr_idx     [num_ports];             // Next free slot
   logic [7:0]        rd_idx     [num_ports];             // Oldest outstanding read
   logic [mem_aw-1:0] written_q  [num_ports][$];          // RAM words each port has written
   int                credits    [num_ports];
   int                cyc = 0;
   int                idle_cnt;                           // Cycles with no request
   int                n_issued;
   int                err_data;
   int                err_lat;
   int                err_credit;
   int                err_proto;

   initial begin
      clk1 = 1'b0;
      forever #10 clk1 = ~clk1;                           // 20 ns period
   end

   mem_subsystem dut (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .credit_ret (credit_ret),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data)
   );

   always @(posedge clk1)
      cyc <= cyc + 1;

   // Credit counters, reply pointer and idle time
   always @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) begin
         for (int p = 0; p < num_ports; p++) begin
            credits[p] <= port_credits;                   // Full credit after reset
            rd_idx[p]  <= '0;
         end
         idle_cnt <= 0;
      end else begin
         for (int p = 0; p < num_ports; p++) begin
            credits[p] <= credits[p] - int'(req_valid[p]) + int'(credit_ret[p]);
            if (rd_valid[p])
               rd_idx[p] <= rd_idx[p] + 1'b1;
         end
         if (|req_valid)
            idle_cnt <= 0;
         else if (idle_cnt < 1000)
            idle_cnt <= idle_cnt + 1;                     // Saturates
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   for (genvar p = 0; p < num_ports; p++) begin : g_chk
      logic [data_w-1:0] exp_head;
      int                lat;
      bit                head_idle;

      assign exp_head  = exp_data[p][rd_idx[p]];
      assign lat       = cyc - 1 - acc_cyc[p][rd_idx[p]];  // Accept edge to rd_valid edge
      assign head_idle = exp_idle[p][rd_idx[p]];

      a_rd_data: assert property (@(posedge clk1) disable iff (!rst_n)
            rd_valid[p] |-> rd_data[p] == exp_head)
         else begin
            err_data++;
            $display("CHECK FAILED t=%0t rd_data[%0d] expected %h got %h",
                     $time, p, $sampled(exp_head), $sampled(rd_data[p]));
         end

      a_no_stray: assert property (@(posedge clk1) disable iff (!rst_n)
            rd_valid[p] |-> rd_idx[p] != wr_idx[p])
         else begin
            err_proto++;
            $display("Port %0d returned a reply at t=%0t with no read outstanding", p, $time);
         end

      // Bounded wait means neither port starves
      a_lat_bound: assert property (@(posedge clk1) disable iff (!rst_n)
            rd_valid[p] |-> lat <= max_lat)
         else begin
            err_lat++;
            $display("CHECK FAILED t=%0t latency[%0d] expected <= %0d got %0d",
                     $time, p, max_lat, $sampled(lat));
         end

      a_lat_idle: assert property (@(posedge clk1) disable iff (!rst_n)
            rd_valid[p] && head_idle |-> lat == idle_lat)
         else begin
            err_lat++;
            $display("CHECK FAILED t=%0t latency[%0d] expected %0d got %0d",
                     $time, p, idle_lat, $sampled(lat));
         end

      a_credit_range: assert property (@(posedge clk1) disable iff (!rst_n)
            credits[p] >= 0 && credits[p] <= int'(port_credits))
         else begin
            err_credit++;
            $display("CHECK FAILED t=%0t credits[%0d] expected 0..%0d got %0d",
                     $time, p, port_credits, $sampled(credits[p]));
         end

      a_credit_home: assert property (@(posedge clk1) disable iff (!rst_n)
            idle_cnt >= idle_wait |-> credits[p] == int'(port_credits))
         else begin
            err_credit++;
            $display("CHECK FAILED t=%0t credits[%0d] expected %0d got %0d",
                     $time, p, port_credits, $sampled(credits[p]));
         end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   // Bits 23:19 select bank and chip as on the board
   function automatic logic [data_w-1:0] ref_read(input logic [addr_w-1:0] a);
      if (a[23:19] == 5'b00000)
         return ram_shadow[a[mem_aw-1:0]];
      else if (a[23:19] == 5'b10000)
         return data_w'(a[mem_aw-1:0]) ^ rom_key;
      else
         return 16'hFFFF;                                 // Pulled-up bus
   endfunction

   function automatic void ref_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
      if (a[23:19] == 5'b00000)
         ram_shadow[a[mem_aw-1:0]] = d;                   // ROM and unmapped drop writes
   endfunction

   function automatic logic [addr_w-1:0] ram_addr(input logic [mem_aw-1:0] off);
      return addr_w'(off);
   endfunction

   function automatic logic [addr_w-1:0] rom_addr(input logic [mem_aw-1:0] off);
      return 24'h800000 | addr_w'(off);
   endfunction

   // Port p owns the RAM words whose parity equals p
   function automatic logic [mem_aw-1:0] own_offset(input int p);
      return mem_aw'(2 * $urandom_range(0, 2**(mem_aw-1) - 1) + p);
   endfunction

   // Waits for a credit, then holds the request for one edge
   task automatic send_req(input int p, input bit wr, input logic [addr_w-1:0] a,
                           input logic [data_w-1:0] d, input bit idle);
      @(posedge clk1);
      while (credits[p] - int'(req_valid[p]) + int'(credit_ret[p]) <= 0) begin
         req_valid[p] <= 1'b0;
         @(posedge clk1);
      end
      req_valid[p]    <= 1'b1;
      req[p].write    <= wr;
      req[p].addr.raw <= a;
      req[p].wdata    <= d;
      if (wr)
         ref_write(a, d);
      else begin
         exp_data[p][wr_idx[p]] = ref_read(a);
         acc_cyc[p][wr_idx[p]]  = cyc + 1;                // DUT takes it next edge
         exp_idle[p][wr_idx[p]] = idle;
         wr_idx[p]              = wr_idx[p] + 1'b1;
      end
      n_issued++;
   endtask

   task automatic release_port(input int p);
      @(posedge clk1);
      req_valid[p] <= 1'b0;
   endtask

   task automatic wait_idle();
      @(posedge clk1);
      req_valid <= '0;
      @(posedge clk1);
      while (credits[0] != int'(port_credits) || credits[1] != int'(port_credits)
             || rd_idx[0] != wr_idx[0] || rd_idx[1] != wr_idx[1])
         @(posedge clk1);
      repeat (idle_wait + 2) @(posedge clk1);             // Lets the credit check fire
   endtask

   task automatic idle_round_trip(input int p);
      logic [mem_aw-1:0] off;
      off = own_offset(p);
      send_req(p, 1'b1, ram_addr(off), 16'($urandom), 1'b0);
      wait_idle();
      send_req(p, 1'b0, ram_addr(off), '0, 1'b1);         // Exact latency expected
      wait_idle();
      written_q[p].push_back(off);
   endtask

   task automatic write_stream(input int p, input int n);
      logic [mem_aw-1:0] off;
      for (int i = 0; i < n; i++) begin
         off = own_offset(p);
         send_req(p, 1'b1, ram_addr(off), 16'($urandom), 1'b0);
         written_q[p].push_back(off);
      end
      release_port(p);
   endtask

   // Reads words written by either port
   task automatic read_stream(input int p, input int n);
      int                src;
      logic [mem_aw-1:0] off;
      for (int i = 0; i < n; i++) begin
         src = $urandom_range(0, num_ports - 1);
         off = written_q[src][$urandom_range(0, written_q[src].size() - 1)];
         send_req(p, 1'b0, ram_addr(off), '0, 1'b0);
      end
      release_port(p);
   endtask

   task automatic rom_stream(input int p);
      logic [mem_aw-1:0] off;
      for (int i = 0; i < rom_words; i++)
         send_req(p, 1'b0, rom_addr(mem_aw'(i)), '0, 1'b0);
      off = mem_aw'(p + 3);
      send_req(p, 1'b1, rom_addr(off), 16'h1234, 1'b0);   // Must be ignored
      send_req(p, 1'b0, rom_addr(off), '0, 1'b0);
      release_port(p);
   endtask

   // Unmapped aliases of a written RAM word
   task automatic unmapped_stream(input int p);
      logic [addr_w-1:0] base [4];
      logic [mem_aw-1:0] off;
      base[0] = 24'h400000;                               // Bit 22 high
      base[1] = 24'h080000;                               // Low decoder chip 1
      base[2] = 24'hC00000;                               // Both enables high
      base[3] = 24'h880000;                               // ROM decoder chip 1
      off = written_q[p][$urandom_range(0, written_q[p].size() - 1)];
      for (int i = 0; i < 4; i++) begin
         send_req(p, 1'b1, base[i] | addr_w'(off), 16'hDEAD ^ 16'(i), 1'b0);
         send_req(p, 1'b0, base[i] | addr_w'(off), '0, 1'b0);
      end
      send_req(p, 1'b0, ram_addr(off), '0, 1'b0);          // RAM word unchanged
      release_port(p);
   endtask

   task automatic mixed_stream(input int p, input int n);
      logic [mem_aw-1:0] off;
      for (int i = 0; i < n; i++) begin
         if ($urandom_range(0, 2) == 0) begin
            off = own_offset(p);
            send_req(p, 1'b1, ram_addr(off), 16'($urandom), 1'b0);
            written_q[p].push_back(off);
         end else begin
            off = written_q[p][$urandom_range(0, written_q[p].size() - 1)];
            send_req(p, 1'b0, ram_addr(off), '0, 1'b0);
         end
      end
      release_port(p);
   endtask

   task automatic print_counts();
      $display("Errors: data=%0d latency=%0d credit=%0d protocol=%0d",
               err_data, err_lat, err_credit, err_proto);
   endtask

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(36141));
      rst_n      = 1'b0;
      req_valid  = '0;
      req        = '0;
      wr_idx[0]  = '0;
      wr_idx[1]  = '0;
      n_issued   = 0;
      err_data   = 0;
      err_lat    = 0;
      err_credit = 0;
      err_proto  = 0;
      repeat (5) @(posedge clk1);
      rst_n <= 1'b1;

      for (int p = 0; p < num_ports; p++)
         idle_round_trip(p);
      fork
         write_stream(0, 24);
         write_stream(1, 24);
      join
      wait_idle();
      fork
         read_stream(0, 32);
         read_stream(1, 32);
      join
      wait_idle();
      fork
         rom_stream(0);
         rom_stream(1);
      join
      wait_idle();
      fork
         unmapped_stream(0);
         unmapped_stream(1);
      join
      wait_idle();
      fork
         mixed_stream(0, 48);
         mixed_stream(1, 48);
      join
      wait_idle();

      print_counts();
      if (err_data + err_lat + err_credit + err_proto == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // Watchdog allows 20 cycles per request plus slack
   initial begin
      while (cyc <= 20 * n_issued + 200)
         @(posedge clk1);
      $display("Timeout after %0d cycles with %0d requests issued", cyc, n_issued);
      print_counts();
      $display("Regression failed");
      $finish;
   end

endmodule
